// ==== common/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and register file
`define RV_XLEN 32
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// data memory, word index taken from address bits 9..2
`define RV_DMEM_WORDS 256
`define RV_DMEM_AW 8

`define RV_RESET_PC 32'h0000_0000

`endif

// ==== common/rv_pkg.sv ====
package rv_pkg;

  // rv32i major opcodes
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add      = 4'd0,
    alu_sub      = 4'd1,
    alu_sll      = 4'd2,
    alu_srl      = 4'd3,
    alu_sra      = 4'd4,
    alu_and      = 4'd5,
    alu_or       = 4'd6,
    alu_xor      = 4'd7,
    alu_pass_imm = 4'd8  // lui
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_beq  = 3'd1,
    br_bne  = 3'd2,
    br_blt  = 3'd3,
    br_bge  = 3'd4,
    br_bltu = 3'd5,
    br_bgeu = 3'd6
  } branch_e;

  typedef enum logic [1:0] {
    wb_alu      = 2'd0,
    wb_mem      = 2'd1,
    wb_pc_plus4 = 2'd2
  } wb_sel_e;

  typedef enum logic [1:0] {
    jmp_none = 2'd0,
    jmp_jal  = 2'd1,  // pc relative
    jmp_jalr = 2'd2   // rs1 relative, bit 0 cleared
  } jump_e;

endpackage

// ==== common/rv_ctrl_if.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

// decoded control and operand fields, valid every cycle
interface rv_ctrl_if;
  rv_pkg::alu_op_e alu_op;
  rv_pkg::branch_e branch;
  rv_pkg::jump_e   jump;
  rv_pkg::wb_sel_e wb_sel;
  logic            alu_src_imm;
  logic            auipc;
  logic            reg_we;
  logic            mem_re;
  logic            mem_we;
  logic            mem_byte;
  logic [`RV_XLEN-1:0]   imm;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_REG_AW-1:0] rd;

  modport decode (
    output alu_op, branch, jump, wb_sel, alu_src_imm, auipc,
    output reg_we, mem_re, mem_we, mem_byte, imm, rs1, rs2, rd
  );

  modport datapath (
    input alu_op, branch, jump, wb_sel, alu_src_imm, auipc,
    input reg_we, mem_re, mem_we, mem_byte, imm, rs1, rs2, rd
  );
endinterface

// ==== decode/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decode (
  input  logic [31:0] inst,
  rv_ctrl_if.decode   ctrl
);

  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            is_reg;
  logic            f7_zero;
  logic            f7_alt;
  logic            arith_ok;
  rv_pkg::alu_op_e arith_op;

  assign opcode  = rv_pkg::opcode_e'(inst[6:0]);
  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign is_reg  = (opcode == rv_pkg::opc_op);
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  assign ctrl.rs1 = inst[19:15];
  assign ctrl.rs2 = inst[24:20];
  assign ctrl.rd  = inst[11:7];

  // funct3/funct7 to alu op, shared by register and immediate forms
  always_comb begin
    arith_ok = 1'b1;
    arith_op = rv_pkg::alu_add;
    case (funct3)
      3'b000: begin
        if (is_reg && f7_alt) arith_op = rv_pkg::alu_sub;
        arith_ok = !is_reg || f7_zero || f7_alt;
      end
      3'b001: begin
        arith_op = rv_pkg::alu_sll;
        arith_ok = f7_zero;
      end
      3'b100: begin
        arith_op = rv_pkg::alu_xor;
        arith_ok = !is_reg || f7_zero;
      end
      3'b101: begin
        if (f7_alt) arith_op = rv_pkg::alu_sra;
        else arith_op = rv_pkg::alu_srl;
        arith_ok = f7_zero || f7_alt;
      end
      3'b110: begin
        arith_op = rv_pkg::alu_or;
        arith_ok = !is_reg || f7_zero;
      end
      3'b111: begin
        arith_op = rv_pkg::alu_and;
        arith_ok = !is_reg || f7_zero;
      end
      default: arith_ok = 1'b0;  // slt/sltu family, not supported
    endcase
  end

  always_comb begin
    ctrl.alu_op      = rv_pkg::alu_add;
    ctrl.branch      = rv_pkg::br_none;
    ctrl.jump        = rv_pkg::jmp_none;
    ctrl.wb_sel      = rv_pkg::wb_alu;
    ctrl.alu_src_imm = 1'b0;
    ctrl.auipc       = 1'b0;
    ctrl.reg_we      = 1'b0;
    ctrl.mem_re      = 1'b0;
    ctrl.mem_we      = 1'b0;
    ctrl.mem_byte    = 1'b0;
    case (opcode)
      rv_pkg::opc_op: begin
        if (arith_ok) begin
          ctrl.alu_op = arith_op;
          ctrl.reg_we = 1'b1;
        end
      end
      rv_pkg::opc_op_imm: begin
        if (arith_ok) begin
          ctrl.alu_op      = arith_op;
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_we      = 1'b1;
        end
      end
      rv_pkg::opc_load: begin
        if (funct3 == 3'b000 || funct3 == 3'b010) begin  // lb, lw
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_we      = 1'b1;
          ctrl.mem_re      = 1'b1;
          ctrl.wb_sel      = rv_pkg::wb_mem;
          ctrl.mem_byte    = (funct3 == 3'b000);
        end
      end
      rv_pkg::opc_store: begin
        if (funct3 == 3'b000 || funct3 == 3'b010) begin  // sb, sw
          ctrl.alu_src_imm = 1'b1;
          ctrl.mem_we      = 1'b1;
          ctrl.mem_byte    = (funct3 == 3'b000);
        end
      end
      rv_pkg::opc_branch: begin
        ctrl.alu_op = rv_pkg::alu_sub;
        case (funct3)
          3'b000:  ctrl.branch = rv_pkg::br_beq;
          3'b001:  ctrl.branch = rv_pkg::br_bne;
          3'b100:  ctrl.branch = rv_pkg::br_blt;
          3'b101:  ctrl.branch = rv_pkg::br_bge;
          3'b110:  ctrl.branch = rv_pkg::br_bltu;
          3'b111:  ctrl.branch = rv_pkg::br_bgeu;
          default: ctrl.branch = rv_pkg::br_none;
        endcase
      end
      rv_pkg::opc_lui: begin
        ctrl.alu_op      = rv_pkg::alu_pass_imm;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_we      = 1'b1;
      end
      rv_pkg::opc_auipc: begin
        ctrl.auipc       = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_we      = 1'b1;
      end
      rv_pkg::opc_jal: begin
        ctrl.jump   = rv_pkg::jmp_jal;
        ctrl.wb_sel = rv_pkg::wb_pc_plus4;
        ctrl.reg_we = 1'b1;
      end
      rv_pkg::opc_jalr: begin
        if (funct3 == 3'b000) begin
          ctrl.jump   = rv_pkg::jmp_jalr;
          ctrl.wb_sel = rv_pkg::wb_pc_plus4;
          ctrl.reg_we = 1'b1;
        end
      end
      default: ;  // no-op
    endcase
  end

  // immediate by format
  always_comb begin
    case (opcode)
      rv_pkg::opc_op_imm, rv_pkg::opc_load, rv_pkg::opc_jalr:
        ctrl.imm = {{20{inst[31]}}, inst[31:20]};
      rv_pkg::opc_store:
        ctrl.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      rv_pkg::opc_branch:
        ctrl.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      rv_pkg::opc_lui, rv_pkg::opc_auipc:
        ctrl.imm = {inst[31:12], 12'd0};
      rv_pkg::opc_jal:
        ctrl.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        ctrl.imm = '0;
    endcase
  end

endmodule

// ==== execute/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_execute (
  rv_ctrl_if.datapath         ctrl,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] result,
  output logic                branch_taken
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] diff;
  logic                carry;   // set when op_a >= op_b unsigned
  logic                zero;
  logic                ovf;
  logic                lt;
  logic [4:0]          shamt;

  assign op_a  = ctrl.auipc ? pc : rs1_data;
  assign op_b  = ctrl.alu_src_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[4:0];

  // one subtractor for sub and the compare flags
  assign {carry, diff} = {1'b0, op_a} + {1'b0, ~op_b} + 33'd1;
  assign zero = (diff == '0);
  assign ovf  = (op_a[`RV_XLEN-1] != op_b[`RV_XLEN-1]) &&
                (diff[`RV_XLEN-1] != op_a[`RV_XLEN-1]);
  assign lt   = diff[`RV_XLEN-1] ^ ovf;

  always_comb begin
    case (ctrl.alu_op)
      rv_pkg::alu_add:      result = op_a + op_b;
      rv_pkg::alu_sub:      result = diff;
      rv_pkg::alu_sll:      result = op_a << shamt;
      rv_pkg::alu_srl:      result = op_a >> shamt;
      rv_pkg::alu_sra:      result = $signed(op_a) >>> shamt;
      rv_pkg::alu_and:      result = op_a & op_b;
      rv_pkg::alu_or:       result = op_a | op_b;
      rv_pkg::alu_xor:      result = op_a ^ op_b;
      rv_pkg::alu_pass_imm: result = ctrl.imm;
      default:              result = '0;
    endcase
  end

  always_comb begin
    case (ctrl.branch)
      rv_pkg::br_beq:  branch_taken = zero;
      rv_pkg::br_bne:  branch_taken = !zero;
      rv_pkg::br_blt:  branch_taken = lt;
      rv_pkg::br_bge:  branch_taken = !lt;
      rv_pkg::br_bltu: branch_taken = !carry;
      rv_pkg::br_bgeu: branch_taken = carry;
      default:         branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  rv_ctrl_if.datapath           ctrl,
  input  logic                  we,
  input  logic [`RV_XLEN-1:0]   wdata,
  input  logic [`RV_REG_AW-1:0] dbg_reg,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data,
  output logic [`RV_XLEN-1:0]   dbg_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // x0 is never written so it keeps its reset value
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && ctrl.rd != '0) begin
      regs[ctrl.rd] <= wdata;
    end
  end

  assign rs1_data = regs[ctrl.rs1];
  assign rs2_data = regs[ctrl.rs2];
  assign dbg_data = regs[dbg_reg];  // debug tap

endmodule

// ==== design/rv_fetch.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                rst,
  rv_ctrl_if.datapath         ctrl,
  input  logic                branch_taken,
  input  logic                stall,
  input  logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] pc_plus4
);

  logic [`RV_XLEN-1:0] pc_rel;
  logic [`RV_XLEN-1:0] pc_reg;
  logic [`RV_XLEN-1:0] pc_next;

  assign pc_plus4 = pc + 32'd4;
  assign pc_rel   = pc + ctrl.imm;
  assign pc_reg   = (rs1_data + ctrl.imm) & ~32'd1;  // jalr clears bit 0

  always_comb begin
    if (stall)
      pc_next = pc;  // memory wait state
    else if (ctrl.jump == rv_pkg::jmp_jal || branch_taken)
      pc_next = pc_rel;
    else if (ctrl.jump == rv_pkg::jmp_jalr)
      pc_next = pc_reg;
    else
      pc_next = pc_plus4;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      pc <= `RV_RESET_PC;
    else
      pc <= pc_next;
  end

endmodule

// ==== design/rv_dmem.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_dmem (
  input  logic                clk,
  input  logic                rst,
  rv_ctrl_if.datapath         ctrl,
  input  logic [`RV_XLEN-1:0] addr,
  input  logic [`RV_XLEN-1:0] wdata,
  output logic [`RV_XLEN-1:0] rdata,
  output logic                stall
);

  typedef enum logic {
    st_idle,
    st_wait
  } state_e;

  state_e state;
  state_e state_next;

  logic [`RV_XLEN-1:0]    mem [`RV_DMEM_WORDS];
  logic [`RV_DMEM_AW-1:0] idx;
  logic [`RV_XLEN-1:0]    word;
  logic                   access;

  assign idx    = addr[`RV_DMEM_AW+1:2];
  assign access = ctrl.mem_re || ctrl.mem_we;

  // every access spends one cycle in idle with the pc held, then one in wait
  always_comb begin
    stall      = 1'b0;
    state_next = state;
    case (state)
      st_idle: begin
        if (access) begin
          stall      = 1'b1;
          state_next = st_wait;
        end
      end
      st_wait: state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      state <= st_idle;
    else
      state <= state_next;
  end

  // sb stores the whole word with the byte zero extended
  always_ff @(posedge clk) begin
    if (ctrl.mem_we && state == st_idle)
      mem[idx] <= ctrl.mem_byte ? {24'd0, wdata[7:0]} : wdata;
  end

  assign word  = mem[idx];
  assign rdata = ctrl.mem_byte ? {24'd0, word[7:0]} : word;

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [31:0]           imem_data,
  input  logic [`RV_REG_AW-1:0] dbg_reg,
  output logic [`RV_XLEN-1:0]   imem_addr,
  output logic [`RV_XLEN-1:0]   pc,
  output logic [`RV_XLEN-1:0]   dbg_data
);

  rv_ctrl_if ctrl ();

  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] result;
  logic [`RV_XLEN-1:0] mem_rdata;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] wb_data;
  logic                branch_taken;
  logic                stall;
  logic                reg_we;

  assign imem_addr = pc;

  // no register write until the memory wait cycle
  assign reg_we = ctrl.reg_we && !stall;

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::wb_mem:      wb_data = mem_rdata;
      rv_pkg::wb_pc_plus4: wb_data = pc_plus4;  // jal/jalr link
      default:             wb_data = result;
    endcase
  end

  rv_decode i_decode (
    .inst (imem_data),
    .ctrl (ctrl)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .we       (reg_we),
    .wdata    (wb_data),
    .dbg_reg  (dbg_reg),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dbg_data (dbg_data)
  );

  rv_execute i_execute (
    .ctrl         (ctrl),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .pc           (pc),
    .result       (result),
    .branch_taken (branch_taken)
  );

  rv_fetch i_fetch (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .branch_taken (branch_taken),
    .stall        (stall),
    .rs1_data     (rs1_data),
    .pc           (pc),
    .pc_plus4     (pc_plus4)
  );

  rv_dmem i_dmem (
    .clk   (clk),
    .rst   (rst),
    .ctrl  (ctrl),
    .addr  (result),
    .wdata (rs2_data),
    .rdata (mem_rdata),
    .stall (stall)
  );

endmodule

// ==== dv/rv_core_assert.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_assert (
  input logic                  clk,
  input logic                  rst,
  input logic [`RV_XLEN-1:0]   pc,
  input logic                  stall,
  input logic [`RV_REG_AW-1:0] dbg_reg,
  input logic [`RV_XLEN-1:0]   dbg_data
);

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc %h is not word aligned", pc);

  // wait state must freeze fetch
  stall_holds_pc: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(pc))
    else $error("pc moved during a memory stall");

  stall_single: assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
    else $error("stall high for two cycles in a row");

  x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
    dbg_reg == '0 |-> dbg_data == '0)
    else $error("x0 reads back %h", dbg_data);

endmodule

bind rv_core rv_core_assert i_assert (
  .clk      (clk),
  .rst      (rst),
  .pc       (pc),
  .stall    (stall),
  .dbg_reg  (dbg_reg),
  .dbg_data (dbg_data)
);

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_tb;

  localparam int CLK_PERIOD = 20;
  localparam int N_PROGS    = 6;
  localparam int PROG_MAX   = 96;
  localparam int PROG_WORDS = 256;
  // 3 cycles per instruction, plus reset, end detection and register readout
  localparam int WATCHDOG_NS = N_PROGS * (PROG_MAX * 3 + 100) * CLK_PERIOD;

  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_IMM    = 7'h13;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;

  logic                  clk;
  logic                  rst;
  logic [31:0]           imem_data;
  logic [`RV_REG_AW-1:0] dbg_reg;
  logic [`RV_XLEN-1:0]   imem_addr;
  logic [`RV_XLEN-1:0]   pc;
  logic [`RV_XLEN-1:0]   dbg_data;

  logic [31:0] prog [PROG_WORDS];
  int          plen;
  logic [31:0] m_regs [`RV_NUM_REGS];  // reference model state
  logic [31:0] m_mem [`RV_DMEM_WORDS];
  logic [31:0] m_pc;
  int          seed;
  bit          running;
  bit          done;
  logic [31:0] last_pc;
  int          cyc_cnt;
  int          exp_cyc;
  int          cur_prog;

  assign imem_data = prog[imem_addr[9:2]];  // instruction memory model

  rv_core i_dut (
    .clk       (clk),
    .rst       (rst),
    .imem_data (imem_data),
    .dbg_reg   (dbg_reg),
    .imem_addr (imem_addr),
    .pc        (pc),
    .dbg_data  (dbg_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int rnd(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [31:0] rnd32();
    return $random(seed);
  endfunction

  // instruction encoders
  // r-type goes through enc_i with funct7 on top
  function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(int off, int rs2, int rs1, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(int imm20, int rd, logic [6:0] opc);
    return {imm20[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_j(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
  endfunction

  function automatic logic [31:0] edge_value();
    case (rnd(6))
      0: return 32'h8000_0000;
      1: return 32'h7fff_ffff;
      2: return 32'hffff_ffff;
      3: return 32'h0;
      default: return rnd32();
    endcase
  endfunction

  task automatic emit(input logic [31:0] inst);
    prog[plen] = inst;
    plen++;
  endtask

  task automatic load_const(input int rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;  // addi sign extends the low 12 bits
    emit(enc_u(int'(hi[31:12]), rd, OPC_LUI));
    emit(enc_i(int'(v[11:0]), rd, 0, rd, OPC_IMM));
  endtask

  // slt family and unknown funct7 decode as no-ops
  function automatic bit arith_legal(bit reg_form, logic [2:0] f3, logic [6:0] f7);
    case (f3)
      3'd0: return !reg_form || f7 == 7'h00 || f7 == 7'h20;
      3'd1: return f7 == 7'h00;
      3'd5: return f7 == 7'h00 || f7 == 7'h20;
      3'd2, 3'd3: return 1'b0;
      default: return !reg_form || f7 == 7'h00;
    endcase
  endfunction

  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd4: return a ^ b;
      3'd5: begin
        if (alt)
          return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branch_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // executes one instruction on the model and returns its cycle count
  function automatic int ref_step();
    logic [31:0] inst;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] ea;
    logic [31:0] nxt;
    logic [31:0] val;
    logic        wr;
    int          cyc;
    inst  = prog[m_pc[9:2]];
    opc   = inst[6:0];
    f3    = inst[14:12];
    f7    = inst[31:25];
    a     = m_regs[inst[19:15]];
    b     = m_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    nxt   = m_pc + 32'd4;
    val   = '0;
    wr    = 1'b0;
    cyc   = 1;
    case (opc)
      OPC_OP, OPC_IMM: begin
        if (arith_legal(opc == OPC_OP, f3, f7)) begin
          wr  = 1'b1;
          val = alu_ref(f3, f7[5] && (opc == OPC_OP || f3 == 3'd5), a,
                        (opc == OPC_OP) ? b : imm_i);
        end
      end
      OPC_LOAD: begin
        if (f3 == 3'd0 || f3 == 3'd2) begin
          ea  = a + imm_i;
          val = m_mem[ea[9:2]];
          if (f3 == 3'd0)
            val = {24'd0, val[7:0]};  // lb zero extends
          wr  = 1'b1;
          cyc = 2;
        end
      end
      OPC_STORE: begin
        if (f3 == 3'd0 || f3 == 3'd2) begin
          ea = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
          m_mem[ea[9:2]] = (f3 == 3'd0) ? {24'd0, b[7:0]} : b;
          cyc = 2;
        end
      end
      OPC_BRANCH: begin
        if (branch_ref(f3, a, b))
          nxt = m_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      OPC_LUI: begin
        wr  = 1'b1;
        val = {inst[31:12], 12'd0};
      end
      OPC_AUIPC: begin
        wr  = 1'b1;
        val = m_pc + {inst[31:12], 12'd0};
      end
      OPC_JAL: begin
        wr  = 1'b1;
        val = m_pc + 32'd4;
        nxt = m_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      OPC_JALR: begin
        if (f3 == 3'd0) begin
          wr  = 1'b1;
          val = m_pc + 32'd4;
          nxt = (a + imm_i) & ~32'd1;
        end
      end
      default: ;
    endcase
    if (wr && inst[11:7] != 5'd0)
      m_regs[inst[11:7]] = val;
    m_pc = nxt;
    return cyc;
  endfunction

  task automatic build_alu();
    int f3;
    int f7;
    for (int r = 1; r < 8; r++) begin
      load_const(r, rnd32());
    end
    for (int i = 0; i < 40; i++) begin
      f3 = rnd(8);
      if (f3 == 2 || f3 == 3)
        f3 = f3 + 2;
      f7 = ((f3 == 0 || f3 == 5) && rnd(2) == 1) ? 32 : 0;
      if (rnd(2) == 0)
        emit(enc_i(f7 * 32 + rnd(8), rnd(8), f3, rnd(8), OPC_OP));
      else if (f3 == 1 || f3 == 5)
        emit(enc_i(f7 * 32 + rnd(32), rnd(8), f3, rnd(8), OPC_IMM));  // shift imm
      else
        emit(enc_i(rnd(4096) - 2048, rnd(8), f3, rnd(8), OPC_IMM));
    end
  endtask

  task automatic build_jumps();
    emit(enc_u(rnd(1 << 20), 1, OPC_LUI));
    emit(enc_u(rnd(1 << 20), 2, OPC_AUIPC));
    emit(enc_j(12, 3));
    emit(enc_i(1, 0, 0, 4, OPC_IMM));
    emit(enc_i(2, 0, 0, 4, OPC_IMM));
    emit(enc_u(0, 5, OPC_AUIPC));
    emit(enc_i(13, 5, 0, 6, OPC_JALR));  // odd target with bit 0 dropped
    emit(enc_i(3, 0, 0, 7, OPC_IMM));
    emit(enc_j(12, 8));
    emit(enc_i(5, 0, 0, 9, OPC_IMM));
    emit(enc_j(8, 10));
    emit(enc_j(-4, 11));                 // backward hop
  endtask

  task automatic build_branches();
    logic [31:0] a;
    logic [31:0] b;
    int          f3;
    for (int i = 0; i < 12; i++) begin
      a = edge_value();
      b = (rnd(4) == 0) ? a : edge_value();
      load_const(1, a);
      load_const(2, b);
      f3 = rnd(6);
      if (f3 >= 2)
        f3 = f3 + 2;
      emit(enc_b(8, 2, 1, f3));            // taken skips the count
      emit(enc_i(1, 3, 0, 3, OPC_IMM));
    end
  endtask

  task automatic build_mem();
    int off [6];
    load_const(10, rnd32() & 32'hffff_fffc);
    for (int i = 0; i < 6; i++) begin
      off[i] = (rnd(1024) - 512) * 4;
      load_const(1, rnd32());
      if (i % 2 == 0)
        emit(enc_s(off[i], 1, 10, 2));
      else
        emit(enc_s(off[i] + rnd(4), 1, 10, 0));
    end
    for (int i = 0; i < 6; i++) begin
      emit(enc_i(off[i], 10, 2, 11 + i, OPC_LOAD));
      emit(enc_i(off[i] + rnd(4), 10, 0, 17 + i, OPC_LOAD));
    end
    emit(enc_s(0, 10, 10, 2));              // store then load back to back
    emit(enc_i(0, 10, 2, 23, OPC_LOAD));
    emit(enc_i(off[0], 10, 2, 0, OPC_LOAD));
  endtask

  task automatic build_unsupported();
    for (int r = 1; r < 8; r++) begin
      load_const(r, rnd32());
    end
    emit(enc_i(3, 2, 2, 1, OPC_OP));        // slt
    emit(enc_i(3, 2, 3, 4, OPC_OP));        // sltu
    emit(enc_i(-1, 2, 2, 5, OPC_IMM));
    emit(enc_i(rnd(4096), rnd(32), rnd(8), 6, 7'h7f));
    emit(enc_i(32 + 3, 2, 0, 7, OPC_OP));   // funct7 outside rv32i
  endtask

  task automatic build_program(input int p);
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = enc_i(i, 0, 0, 0, OPC_IMM);
    end
    plen = 0;
    case (p)
      1: build_alu();
      2: build_jumps();
      3: build_branches();
      4: build_mem();
      5: build_unsupported();
      default: ;  // reset only
    endcase
    emit(enc_j(0, 0));  // end loop
  endtask

  task automatic compare_regs();
    for (int r = 0; r < `RV_NUM_REGS; r++) begin
      @(posedge clk);
      #2;
      dbg_reg = r[4:0];
      @(negedge clk);
      check_value($sformatf("dbg_data x%0d", r), dbg_data, m_regs[r]);
    end
  endtask

  task automatic run_program(input int p);
    @(posedge clk);
    #2;
    rst = 1'b1;
    build_program(p);
    for (int r = 0; r < `RV_NUM_REGS; r++) begin
      m_regs[r] = '0;
    end
    m_pc = `RV_RESET_PC;
    repeat (10) @(posedge clk);
    #2;
    rst     = 1'b0;
    last_pc = `RV_RESET_PC;
    cyc_cnt = 0;
    done    = 1'b0;
    running = 1'b1;
    wait (done);
    running = 1'b0;
    check_value("end pc", pc, 32'(4 * (plen - 1)));
    compare_regs();
  endtask

  // steps the model on every pc change
  always @(negedge clk) begin
    if (running && !done) begin
      if (pc !== last_pc) begin
        exp_cyc = ref_step();
        check_value("pc", pc, m_pc);
        check_value("imem_addr", imem_addr, m_pc);
        check_value($sformatf("cycles at pc %h", last_pc), cyc_cnt, exp_cyc);
        last_pc = pc;
        cyc_cnt = 1;
      end else begin
        cyc_cnt++;
        if (cyc_cnt == 3)
          done = 1'b1;  // parked on jal x0,0
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: program %0d never reached its end loop", cur_prog);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    seed     = 32'h3950_7f0f;
    rst      = 1'b1;
    dbg_reg  = '0;
    running  = 1'b0;
    done     = 1'b0;
    last_pc  = '0;
    cyc_cnt  = 0;
    cur_prog = 0;
    build_program(0);
    for (int p = 0; p < N_PROGS; p++) begin
      cur_prog = p;
      run_program(p);
    end
    $display("No errors");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+common
common/rv_pkg.sv
common/rv_ctrl_if.sv
decode/rv_decode.sv
execute/rv_execute.sv
design/rv_regfile.sv
design/rv_fetch.sv
design/rv_dmem.sv
design/rv_core.sv
dv/rv_core_assert.sv
dv/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0
